// ==== include/fret_defs.svh ====
// sizes, tempo table and active-low segment patterns; BPM values assume whole-minute beats
`ifndef FRET_DEFS_SVH
`define FRET_DEFS_SVH

`define FRET_STRINGS 6
`define FRET_BARS    4
`define FRET_ROWS    5          // four bars plus the open row
`define NOTE_W       32         // grid uses 30 bits, top two stay zero
`define TAKE_DEPTH   64
`define ADDR_W       6
`define SPEED_W      3

// beats per minute per speed select
`define BPM_0 40
`define BPM_1 60
`define BPM_2 80
`define BPM_3 100
`define BPM_4 120
`define BPM_5 140
`define BPM_6 180
`define BPM_7 220

// segments g..a, low lights the segment
`define SEG_0     7'b100_0000
`define SEG_1     7'b111_1001
`define SEG_2     7'b010_0100
`define SEG_3     7'b011_0000
`define SEG_4     7'b001_1001
`define SEG_5     7'b001_0010
`define SEG_6     7'b000_0010
`define SEG_7     7'b111_1000
`define SEG_8     7'b000_0000
`define SEG_9     7'b001_1000
`define SEG_A     7'b000_1000
`define SEG_B     7'b000_0011
`define SEG_C     7'b100_0110
`define SEG_D     7'b010_0001
`define SEG_E     7'b000_0110
`define SEG_F     7'b000_1110
`define SEG_BLANK 7'b111_1111

`endif

// ==== logic/fret_pkg.sv ====
// shared types of the note recorder; widths come from fret_defs.svh on the include path
`include "fret_defs.svh"

package fret_pkg;

	typedef logic [`FRET_STRINGS-1:0] strings_t;   // one bit per string
	typedef logic [`FRET_BARS-1:0]    bars_t;      // bar 1 in bit 0
	typedef logic [`NOTE_W-1:0]       note_t;      // one-hot grid, row * 6 + string
	typedef logic [`ADDR_W-1:0]       addr_t;      // take memory address
	typedef logic [`SPEED_W-1:0]      speed_t;     // tempo table index

	typedef logic [3:0]  digit_t;
	typedef logic [6:0]  seg_t;       // g..a, active low
	typedef logic [31:0] beat_cnt_t;

	// recorder mode, value also shown on the mode display
	typedef enum logic [1:0] {
		MODE_IDLE   = 2'd0,
		MODE_RECORD = 2'd1,
		MODE_PLAY   = 2'd2
	} rec_mode_t;

endpackage

// ==== logic/tempo_timer.sv ====
// beat strobe every clk_per_sec*60/bpm cycles; speed only takes effect on a counter reload
`timescale 1ns/1ps
`include "fret_defs.svh"

module tempo_timer #(
	parameter int clk_per_sec = 50_000_000
) (
	input  logic             clk,
	input  logic             resetn,
	input  fret_pkg::speed_t speed,
	output logic             beat
);
	import fret_pkg::*;

	// 64-bit so the product does not overflow at 50 MHz
	localparam longint TICKS_PER_MIN = longint'(clk_per_sec) * 60;

	beat_cnt_t period;
	beat_cnt_t cnt_q;

	always_comb begin
		case (speed)
			3'd0: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_0);
			3'd1: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_1);
			3'd2: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_2);
			3'd3: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_3);
			3'd4: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_4);
			3'd5: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_5);
			3'd6: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_6);
			default: period = beat_cnt_t'(TICKS_PER_MIN / `BPM_7);
		endcase
	end

	// count down, reload on zero
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt_q <= period - 1'b1;
		end else if (cnt_q == '0) begin
			cnt_q <= period - 1'b1;   // new speed picked up here
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign beat = (cnt_q == '0);

endmodule

// ==== logic/fret_sampler.sv ====
// gathers presses since the last beat, inputs active high; the highest bar wins the row
`timescale 1ns/1ps
`include "fret_defs.svh"

module fret_sampler (
	input  logic               clk,
	input  logic               resetn,
	input  fret_pkg::strings_t strings,
	input  fret_pkg::bars_t    bars,
	input  logic               beat,
	output fret_pkg::note_t    note_code
);
	import fret_pkg::*;

	localparam int ROW_SEL_W = $clog2(`FRET_ROWS);

	strings_t              str_q;      // sticky strings
	strings_t              str_all;
	logic [`FRET_ROWS-1:0] row_q;      // sticky row flags, row 0 is open
	logic [`FRET_ROWS-1:0] row_now;
	logic [`FRET_ROWS-1:0] row_all;
	logic [ROW_SEL_W-1:0]  row_sel;

	// bar priority, later bars overwrite earlier ones
	always_comb begin
		row_sel = '0;
		for (int b = 0; b < `FRET_BARS; b++) begin
			if (bars[b])
				row_sel = ROW_SEL_W'(b + 1);
		end
		row_now = '0;
		row_now[row_sel] = 1'b1;
	end

	assign str_all = str_q | strings;
	assign row_all = row_q | row_now;

	// grid bit at row r, string s
	always_comb begin
		note_code = '0;
		for (int r = 0; r < `FRET_ROWS; r++) begin
			for (int s = 0; s < `FRET_STRINGS; s++) begin
				note_code[r * `FRET_STRINGS + s] = row_all[r] & str_all[s];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || beat) begin
			str_q <= '0;      // beat cycle already used note_code
			row_q <= '0;
		end else begin
			str_q <= str_all;
			row_q <= row_all;
		end
	end

endmodule

// ==== logic/take_recorder.sv ====
// one note per beat into a 64-word take; strobes outside their mode are dropped, stop beats beat
`timescale 1ns/1ps
`include "fret_defs.svh"

module take_recorder (
	input  logic                clk,
	input  logic                resetn,
	input  logic                beat,
	input  fret_pkg::note_t     note_code,
	input  logic                rec_start,
	input  logic                play_start,
	input  logic                stop,
	output fret_pkg::rec_mode_t mode,
	output fret_pkg::note_t     note_out,
	output logic                note_valid
);
	import fret_pkg::*;

	note_t mem [`TAKE_DEPTH];

	rec_mode_t         mode_q;
	addr_t             addr_q;
	logic [`ADDR_W:0]  len_q;        // holds 0..64
	logic [`ADDR_W:0]  addr_next;    // one bit wider to see the wrap
	logic              wr_en;

	assign addr_next = {1'b0, addr_q} + 1'b1;
	assign wr_en     = (mode_q == MODE_RECORD) && beat && !stop;

	// take memory, no reset
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[addr_q] <= note_code;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mode_q     <= MODE_IDLE;
			addr_q     <= '0;
			len_q      <= '0;
			note_out   <= '0;
			note_valid <= 1'b0;
		end else begin
			note_valid <= 1'b0;
			case (mode_q)
				MODE_IDLE: begin
					note_out <= '0;
					if (rec_start) begin
						addr_q <= '0;
						mode_q <= MODE_RECORD;
					end else if (play_start && len_q != '0) begin
						addr_q <= '0;
						mode_q <= MODE_PLAY;
					end
				end
				MODE_RECORD: begin
					if (stop) begin
						len_q  <= {1'b0, addr_q};   // writes done so far
						mode_q <= MODE_IDLE;
					end else if (beat) begin
						note_out   <= note_code;
						note_valid <= 1'b1;
						addr_q     <= addr_next[`ADDR_W-1:0];
						// memory full
						if (addr_next == `TAKE_DEPTH) begin
							len_q  <= addr_next;
							mode_q <= MODE_IDLE;
						end
					end
				end
				MODE_PLAY: begin
					if (stop) begin
						mode_q <= MODE_IDLE;
					end else if (beat) begin
						note_out   <= mem[addr_q];
						note_valid <= 1'b1;
						addr_q     <= addr_next[`ADDR_W-1:0];
						if (addr_next == len_q)
							mode_q <= MODE_IDLE;   // last note of the take
					end
				end
				default: begin
					mode_q <= MODE_IDLE;
				end
			endcase
		end
	end

	assign mode = mode_q;

endmodule

// ==== logic/note_display.sv ====
// three active-low digits: low half, high half of the note, and the mode; non one-hot shows F
`timescale 1ns/1ps
`include "fret_defs.svh"

module note_display (
	input  fret_pkg::note_t     note_out,
	input  fret_pkg::rec_mode_t mode,
	output fret_pkg::seg_t      hex0,
	output fret_pkg::seg_t      hex1,
	output fret_pkg::seg_t      hex_mode
);
	import fret_pkg::*;

	// index of the single set bit, F otherwise
	function automatic digit_t onehot_digit(input logic [15:0] half);
		digit_t digit;
		int     hits;
		digit = 4'hF;
		hits  = 0;
		for (int i = 0; i < 16; i++) begin
			if (half[i]) begin
				digit = digit_t'(i);
				hits++;
			end
		end
		if (hits != 1)
			digit = 4'hF;
		return digit;
	endfunction

	function automatic seg_t hex_seg(input digit_t digit);
		case (digit)
			4'h0: return `SEG_0;
			4'h1: return `SEG_1;
			4'h2: return `SEG_2;
			4'h3: return `SEG_3;
			4'h4: return `SEG_4;
			4'h5: return `SEG_5;
			4'h6: return `SEG_6;
			4'h7: return `SEG_7;
			4'h8: return `SEG_8;
			4'h9: return `SEG_9;
			4'hA: return `SEG_A;
			4'hB: return `SEG_B;
			4'hC: return `SEG_C;
			4'hD: return `SEG_D;
			4'hE: return `SEG_E;
			default: return `SEG_F;
		endcase
	endfunction

	assign hex0 = hex_seg(onehot_digit(note_out[15:0]));
	assign hex1 = hex_seg(onehot_digit(note_out[31:16]));

	always_comb begin
		case (mode)
			MODE_IDLE, MODE_RECORD, MODE_PLAY: hex_mode = hex_seg(digit_t'(mode));
			default: hex_mode = `SEG_BLANK;   // unused encoding
		endcase
	end

endmodule

// ==== logic/fret_recorder_top.sv ====
// note recorder top, all inputs active high; clk_per_sec scales the tempo table
`timescale 1ns/1ps

module fret_recorder_top #(
	parameter int clk_per_sec = 50_000_000
) (
	input  logic                clk,
	input  logic                resetn,
	input  fret_pkg::strings_t  strings,
	input  fret_pkg::bars_t     bars,
	input  fret_pkg::speed_t    speed,
	input  logic                rec_start,
	input  logic                play_start,
	input  logic                stop,
	output fret_pkg::rec_mode_t mode,
	output fret_pkg::note_t     note_out,
	output logic                note_valid,
	output fret_pkg::seg_t      hex0,
	output fret_pkg::seg_t      hex1,
	output fret_pkg::seg_t      hex_mode
);

	logic            beat;
	fret_pkg::note_t note_code;

	tempo_timer #(
		.clk_per_sec(clk_per_sec)
	) u_tempo (
		.clk    (clk),
		.resetn (resetn),
		.speed  (speed),
		.beat   (beat)
	);

	fret_sampler u_sampler (
		.clk       (clk),
		.resetn    (resetn),
		.strings   (strings),
		.bars      (bars),
		.beat      (beat),
		.note_code (note_code)
	);

	take_recorder u_recorder (
		.clk        (clk),
		.resetn     (resetn),
		.beat       (beat),
		.note_code  (note_code),
		.rec_start  (rec_start),
		.play_start (play_start),
		.stop       (stop),
		.mode       (mode),
		.note_out   (note_out),
		.note_valid (note_valid)
	);

	// display follows the registered recorder outputs
	note_display u_display (
		.note_out (note_out),
		.mode     (mode),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex_mode (hex_mode)
	);

endmodule

// ==== dv/fret_recorder_asserts.sv ====
// bound to fret_recorder_top; compares its outputs with the model state in tb_fret_recorder
`timescale 1ns/1ps

module fret_recorder_asserts (
	input logic                clk,
	input logic                resetn,
	input fret_pkg::rec_mode_t mode,
	input fret_pkg::note_t     note_out,
	input logic                note_valid,
	input fret_pkg::seg_t      hex0,
	input fret_pkg::seg_t      hex1,
	input fret_pkg::seg_t      hex_mode
);
	import fret_pkg::*;

	int fails = 0;   // watched by the testbench

	a_mode: assert property (@(posedge clk) disable iff (!resetn)
		mode == tb_fret_recorder.exp_mode)
		else begin
			fails++;
			$error("FAIL %0t mode got %0d exp %0d", $time, mode, tb_fret_recorder.exp_mode);
		end

	a_valid: assert property (@(posedge clk) disable iff (!resetn)
		note_valid == tb_fret_recorder.exp_valid)
		else begin
			fails++;
			$error("FAIL %0t note_valid got %b exp %b", $time, note_valid,
				tb_fret_recorder.exp_valid);
		end

	a_note: assert property (@(posedge clk) disable iff (!resetn)
		note_out == tb_fret_recorder.exp_note)
		else begin
			fails++;
			$error("FAIL %0t note_out got %h exp %h", $time, note_out,
				tb_fret_recorder.exp_note);
		end

	// display digits and mode pattern
	a_hex: assert property (@(posedge clk) disable iff (!resetn)
		hex0 == tb_fret_recorder.exp_hex0 && hex1 == tb_fret_recorder.exp_hex1 &&
		hex_mode == tb_fret_recorder.exp_hex_mode)
		else begin
			fails++;
			$error("FAIL %0t hex0/hex1/hex_mode got %h/%h/%h exp %h/%h/%h", $time,
				hex0, hex1, hex_mode, tb_fret_recorder.exp_hex0,
				tb_fret_recorder.exp_hex1, tb_fret_recorder.exp_hex_mode);
		end

endmodule

// ==== dv/tb_fret_recorder.sv ====
// testbench for fret_recorder_top at clk_per_sec 400; the bound assertion module does the checking
`timescale 1ns/1ps
`include "fret_defs.svh"

module tb_fret_recorder;
	import fret_pkg::*;

	localparam int CPS         = 400;
	localparam int SUM_PERIODS = 600 + 400 + 300 + 240 + 200 + 171 + 133 + 109;
	// seven beats per speed round plus two 64-note takes at the fastest speed
	localparam int WATCHDOG_NS = 2 * (7 * SUM_PERIODS + 130 * 109) * 10 + 2000;

	logic      clk;
	logic      resetn;
	strings_t  strings;
	bars_t     bars;
	speed_t    speed;
	logic      rec_start;
	logic      play_start;
	logic      stop;
	rec_mode_t mode;
	note_t     note_out;
	logic      note_valid;
	seg_t      hex0;
	seg_t      hex1;
	seg_t      hex_mode;

	integer seed;
	logic   press_en;
	logic   hold_press;   // current beat window keeps one press
	logic   new_window;

	// reference model state
	beat_cnt_t        m_cnt;
	logic             m_beat;
	strings_t         m_str;
	logic [4:0]       m_row;
	int               m_addr;
	note_t            take[$];
	rec_mode_t        exp_mode;
	note_t            exp_note;
	logic             exp_valid;
	seg_t             exp_hex0;
	seg_t             exp_hex1;
	seg_t             exp_hex_mode;

	fret_recorder_top #(
		.clk_per_sec(CPS)
	) uut (
		.clk        (clk),
		.resetn     (resetn),
		.strings    (strings),
		.bars       (bars),
		.speed      (speed),
		.rec_start  (rec_start),
		.play_start (play_start),
		.stop       (stop),
		.mode       (mode),
		.note_out   (note_out),
		.note_valid (note_valid),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex_mode   (hex_mode)
	);

	bind fret_recorder_top fret_recorder_asserts u_asserts (
		.clk        (clk),
		.resetn     (resetn),
		.mode       (mode),
		.note_out   (note_out),
		.note_valid (note_valid),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex_mode   (hex_mode)
	);

	function automatic beat_cnt_t period_of(input speed_t sp);
		int bpm;
		case (sp)
			3'd0: bpm = 40;
			3'd1: bpm = 60;
			3'd2: bpm = 80;
			3'd3: bpm = 100;
			3'd4: bpm = 120;
			3'd5: bpm = 140;
			3'd6: bpm = 180;
			default: bpm = 220;
		endcase
		return beat_cnt_t'(CPS * 60 / bpm);
	endfunction

	// open row 0 unless a bar is held, highest bar first
	function automatic logic [4:0] row_of(input bars_t b);
		logic [4:0] r;
		r = 5'b00001;
		if (b[3])
			r = 5'b10000;
		else if (b[2])
			r = 5'b01000;
		else if (b[1])
			r = 5'b00100;
		else if (b[0])
			r = 5'b00010;
		return r;
	endfunction

	function automatic note_t grid(input strings_t s, input logic [4:0] r);
		note_t g;
		g = '0;
		for (int i = 0; i < 5; i++)
			for (int j = 0; j < 6; j++)
				g[i * 6 + j] = r[i] & s[j];
		return g;
	endfunction

	function automatic seg_t seg_of(input logic [15:0] half);
		seg_t tbl [16];
		int   idx;
		tbl = '{`SEG_0, `SEG_1, `SEG_2, `SEG_3, `SEG_4, `SEG_5, `SEG_6, `SEG_7,
			`SEG_8, `SEG_9, `SEG_A, `SEG_B, `SEG_C, `SEG_D, `SEG_E, `SEG_F};
		idx = 15;
		if ($countones(half) == 1)
			for (int i = 0; i < 16; i++)
				if (half[i])
					idx = i;
		return tbl[idx];
	endfunction

	assign m_beat       = (m_cnt == '0);
	assign exp_hex0     = seg_of(exp_note[15:0]);
	assign exp_hex1     = seg_of(exp_note[31:16]);
	assign exp_hex_mode = seg_of(16'h1 << exp_mode);

	always @(posedge clk) begin : model
		note_t g;
		g = grid(m_str | strings, m_row | row_of(bars));
		if (!resetn) begin
			m_cnt     <= period_of(speed) - 1;
			m_str     <= '0;
			m_row     <= '0;
			m_addr    <= 0;
			exp_mode  <= MODE_IDLE;
			exp_note  <= '0;
			exp_valid <= 1'b0;
		end else begin
			m_cnt     <= m_beat ? period_of(speed) - 1 : m_cnt - 1;
			m_str     <= m_beat ? '0 : (m_str | strings);
			m_row     <= m_beat ? '0 : (m_row | row_of(bars));
			exp_valid <= 1'b0;
			case (exp_mode)
				MODE_IDLE: begin
					exp_note <= '0;
					if (rec_start) begin
						take.delete();
						exp_mode <= MODE_RECORD;
					end else if (play_start && take.size() != 0) begin
						m_addr   <= 0;
						exp_mode <= MODE_PLAY;
					end
				end
				MODE_RECORD: begin
					if (stop) begin
						exp_mode <= MODE_IDLE;
					end else if (m_beat) begin
						take.push_back(g);
						exp_note  <= g;
						exp_valid <= 1'b1;
						if (take.size() == 64)
							exp_mode <= MODE_IDLE;
					end
				end
				default: begin
					if (stop) begin
						exp_mode <= MODE_IDLE;
					end else if (m_beat) begin
						exp_note  <= take[m_addr];
						exp_valid <= 1'b1;
						m_addr    <= m_addr + 1;
						if (m_addr + 1 == take.size())
							exp_mode <= MODE_IDLE;
					end
				end
			endcase
		end
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// each beat window holds one press for one-hot notes or gets sparse random presses
	always @(negedge clk) begin : presses
		integer r;
		if (press_en) begin
			r = $random(seed);
			if (new_window) begin
				hold_press = r[20];
				strings    = strings_t'(1) << (r[23:21] % 6);
				bars       = r[24] ? (bars_t'(1) << r[26:25]) : '0;
			end else if (!hold_press) begin
				strings = (r[3:0] == 4'd0) ? r[9:4] : '0;
				bars    = (r[13:11] == 3'd0) ? r[17:14] : '0;
			end
			new_window = m_beat;   // sticky state clears on the coming edge
		end
	end

	task automatic pulse(ref logic sig);
		@(negedge clk);
		sig = 1'b1;
		@(negedge clk);
		sig = 1'b0;
	endtask

	task automatic wait_valid(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (note_valid)
				seen++;
		end
	endtask

	task automatic wait_idle();
		while (mode != MODE_IDLE)
			@(negedge clk);
	endtask

	always @(uut.u_asserts.fails) begin
		if (uut.u_asserts.fails != 0) begin
			$display("Checks failed");
			$fatal(1, "assertion failure in the bound checker");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("Checks failed");
		$fatal(1, "timeout");
	end

	initial begin
		seed       = 32'h874a_e0b3;
		resetn     = 1'b0;
		strings    = '0;
		bars       = '0;
		speed      = '0;
		rec_start  = 1'b0;
		play_start = 1'b0;
		stop       = 1'b0;
		press_en   = 1'b0;
		hold_press = 1'b0;
		new_window = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		repeat (20) @(negedge clk);   // idle after reset
		press_en = 1'b1;
		for (int sp = 0; sp < 8; sp++) begin
			speed = speed_t'(sp);
			pulse(rec_start);
			wait_valid(3);
			pulse(stop);
			wait_idle();
			pulse(play_start);
			wait_idle();
		end
		speed = 3'd7;
		pulse(rec_start);
		wait_idle();                  // full take ends on its own
		pulse(play_start);
		wait_idle();
		repeat (5) @(negedge clk);
		if (uut.u_asserts.fails == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "errors were reported");
		end
	end

endmodule

// ==== src.f ====
+incdir+include
logic/fret_pkg.sv
logic/tempo_timer.sv
logic/fret_sampler.sv
logic/take_recorder.sv
logic/note_display.sv
logic/fret_recorder_top.sv
dv/fret_recorder_asserts.sv
dv/tb_fret_recorder.sv
